// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_instruction_fetcher -f tb.f -o sim_fetch

./obj_dir/sim_fetch +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    exit 0
fi
exit 1

// File: source/fetch_bus_pkg.sv
// Structs exchanged with the instruction cache, the dispatcher and the ROB
`default_nettype none

`include "fetch_macros.svh"

package fetch_bus_pkg;

    // Request to the instruction cache
    typedef struct packed {
        logic             en;   // High until the data strobe returns
        logic [`XLEN-1:0] pc;
    } cache_req_t;

    // Packet handed to the dispatcher
    typedef struct packed {
        logic               valid;          // One-cycle pulse
        logic [`XLEN-1:0]   pc;
        fetch_isa_pkg::op_e op;
        logic [`REG_W-1:0]  rs1;
        logic [`REG_W-1:0]  rs2;
        logic [`REG_W-1:0]  rd;
        logic [`XLEN-1:0]   imm;
        logic               predict_taken;  // Prediction used for this PC
    } issue_t;

    // PC redirect from a ROB flush or the fetch controller
    typedef struct packed {
        logic             load;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: source/fetch_control.sv
// Fetch FSM driving the cache request, instruction register and issue packet
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_control (
    input  wire logic                     clk_in,
    input  wire logic                     rst_in,
    input  wire logic                     rdy_in,
    input  wire logic [`XLEN-1:0]         pc,
    input  wire logic                     icache_data_en,
    input  wire logic [`XLEN-1:0]         icache_data,
    input  fetch_isa_pkg::decoded_t       dec,
    input  wire logic                     predict_result,
    input  wire logic                     new_instruction_able,
    input  fetch_bus_pkg::redirect_t      flush,
    input  wire logic                     jalr_result_en,
    input  wire logic [`XLEN-1:0]         jalr_result,
    output fetch_bus_pkg::cache_req_t     cache_req,
    output logic [`XLEN-1:0]              insn,
    output fetch_bus_pkg::issue_t         issue,
    output logic                          advance,
    output fetch_bus_pkg::redirect_t      pc_load
);

    typedef enum logic [1:0] {
        st_idle       = 2'd0,
        st_wait_cache = 2'd1,
        st_wait_jalr  = 2'd2,
        st_issuing    = 2'd3
    } state_e;

    state_e state;
    logic   jalr_done;

    assign jalr_done = (state == st_wait_jalr) && jalr_result_en;

    // Issue happens exactly when the PC advances
    assign advance = rdy_in && !flush.load && (state == st_issuing) && new_instruction_able;

    assign pc_load.load   = rdy_in && (flush.load || jalr_done);
    assign pc_load.target = (flush.load) ? flush.target : jalr_result;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state        <= st_idle;
            cache_req.en <= 1'b0;
            issue.valid  <= 1'b0;
        end else if (rdy_in) begin
            if (flush.load) begin
                state        <= st_idle;
                cache_req.en <= 1'b0;
                issue.valid  <= 1'b0;
            end else begin
                issue.valid <= 1'b0;   // Pulse lasts one cycle
                case (state)
                    st_idle: begin
                        cache_req.en <= 1'b1;
                        cache_req.pc <= pc;
                        state        <= st_wait_cache;
                    end
                    st_wait_cache: begin
                        if (icache_data_en) begin
                            cache_req.en <= 1'b0;
                            insn         <= icache_data;
                            state        <= st_issuing;
                        end
                    end
                    st_issuing: begin
                        if (new_instruction_able) begin
                            issue.valid         <= 1'b1;
                            issue.pc            <= pc;
                            issue.op            <= dec.op;
                            issue.rs1           <= dec.rs1;
                            issue.rs2           <= dec.rs2;
                            issue.rd            <= dec.rd;
                            issue.imm           <= dec.imm;
                            issue.predict_taken <= predict_result;
                            if (dec.flow == fetch_isa_pkg::flow_indirect) begin
                                state <= st_wait_jalr;
                            end else begin
                                state <= st_idle;
                            end
                        end
                    end
                    default: begin   // st_wait_jalr
                        if (jalr_result_en) state <= st_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_isa_pkg.sv
// RV32I opcode fields, internal operation codes and the decoded instruction
`default_nettype none

`include "fetch_macros.svh"

package fetch_isa_pkg;

    // Major opcode in instruction bits 6:0
    typedef enum logic [6:0] {
        maj_lui    = 7'b0110111,
        maj_auipc  = 7'b0010111,
        maj_jal    = 7'b1101111,
        maj_jalr   = 7'b1100111,
        maj_branch = 7'b1100011,
        maj_load   = 7'b0000011,
        maj_store  = 7'b0100011,
        maj_op_imm = 7'b0010011,
        maj_op     = 7'b0110011
    } major_e;

    // Operation code seen by the dispatcher
    typedef enum logic [6:0] {
        op_none = 7'd0,
        op_lui  = 7'd1,  op_auipc = 7'd2,  op_jal  = 7'd3,  op_jalr = 7'd4,
        op_beq  = 7'd5,  op_bne   = 7'd6,  op_blt  = 7'd7,  op_bge  = 7'd8,
        op_bltu = 7'd9,  op_bgeu  = 7'd10,
        op_lb   = 7'd11, op_lh    = 7'd12, op_lw   = 7'd13, op_lbu  = 7'd14,
        op_lhu  = 7'd15,
        op_sb   = 7'd16, op_sh    = 7'd17, op_sw   = 7'd18,
        op_addi = 7'd19, op_slti  = 7'd20, op_sltiu = 7'd21, op_xori = 7'd22,
        op_ori  = 7'd23, op_andi  = 7'd24, op_slli = 7'd25, op_srli = 7'd26,
        op_srai = 7'd27,
        op_add  = 7'd28, op_sub   = 7'd29, op_sll  = 7'd30, op_slt  = 7'd31,
        op_sltu = 7'd32, op_xor   = 7'd33, op_srl  = 7'd34, op_sra  = 7'd35,
        op_or   = 7'd36, op_and   = 7'd37
    } op_e;

    // How the instruction picks the next PC
    typedef enum logic [1:0] {
        flow_seq      = 2'd0,
        flow_jump     = 2'd1,
        flow_branch   = 2'd2,
        flow_indirect = 2'd3   // Target comes back from the ROB
    } flow_e;

    typedef struct packed {
        op_e               op;
        logic [`REG_W-1:0] rs1;
        logic [`REG_W-1:0] rs2;
        logic [`REG_W-1:0] rd;
        logic [`XLEN-1:0]  imm;   // Already sign-extended
        flow_e             flow;
    } decoded_t;

endpackage

`default_nettype wire

// File: source/fetch_macros.svh
// Fetch stage widths, instruction step and reset PC
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Machine word width for PC, instruction and immediate
`define XLEN 32

// Register index into the 32-entry file
`define REG_W 5

// Byte step between sequential RV32I instructions
`define INSN_BYTES 4

// First PC after reset
`define RESET_PC 32'h0000_0000

`endif

// File: source/instruction_fetcher.sv
// Instruction fetch stage top that joins the FSM, PC unit and decoder
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module instruction_fetcher (
    input  wire logic                     clk_in,
    input  wire logic                     rst_in,
    input  wire logic                     rdy_in,
    input  wire logic                     icache_data_en,
    input  wire logic [`XLEN-1:0]         icache_data,
    input  wire logic                     predict_result,
    input  wire logic                     new_instruction_able,
    input  fetch_bus_pkg::redirect_t      flush,
    input  wire logic                     jalr_result_en,
    input  wire logic [`XLEN-1:0]         jalr_result,
    output fetch_bus_pkg::cache_req_t     cache_req,
    output fetch_bus_pkg::issue_t         issue
);

    logic [`XLEN-1:0]           pc;
    logic [`XLEN-1:0]           insn;
    logic                       advance;
    fetch_bus_pkg::redirect_t   pc_load;
    fetch_isa_pkg::decoded_t    dec;

    fetch_control u_fetch_control (
        .clk_in               (clk_in),
        .rst_in               (rst_in),
        .rdy_in               (rdy_in),
        .pc                   (pc),
        .icache_data_en       (icache_data_en),
        .icache_data          (icache_data),
        .dec                  (dec),
        .predict_result       (predict_result),
        .new_instruction_able (new_instruction_able),
        .flush                (flush),
        .jalr_result_en       (jalr_result_en),
        .jalr_result          (jalr_result),
        .cache_req            (cache_req),
        .insn                 (insn),
        .issue                (issue),
        .advance              (advance),
        .pc_load              (pc_load)
    );

    pc_unit u_pc_unit (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .advance        (advance),
        .pc_load        (pc_load),
        .dec            (dec),
        .predict_result (predict_result),
        .pc             (pc)
    );

    // Decodes the held word, so dec is stable while issuing
    rv32_decoder u_rv32_decoder (
        .insn (insn),
        .dec  (dec)
    );

endmodule

`default_nettype wire

// File: source/pc_unit.sv
// Program counter with next-PC selection from the decoded flow class
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module pc_unit (
    input  wire logic                     clk_in,
    input  wire logic                     rst_in,
    input  wire logic                     advance,
    input  fetch_bus_pkg::redirect_t      pc_load,
    input  fetch_isa_pkg::decoded_t       dec,
    input  wire logic                     predict_result,
    output logic [`XLEN-1:0]              pc
);

    logic [`XLEN-1:0] seq_pc;
    logic [`XLEN-1:0] target_pc;
    logic [`XLEN-1:0] next_pc;

    assign seq_pc    = pc + `XLEN'(`INSN_BYTES);
    assign target_pc = pc + dec.imm;   // jal and taken branch share one adder

    always_comb begin
        case (dec.flow)
            fetch_isa_pkg::flow_jump:     next_pc = target_pc;
            fetch_isa_pkg::flow_branch:   next_pc = (predict_result) ? target_pc : seq_pc;
            fetch_isa_pkg::flow_indirect: next_pc = pc;   // Wait for the jalr result
            default:                      next_pc = seq_pc;
        endcase
    end

    // A redirect wins over a normal advance
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc <= `RESET_PC;
        end else if (pc_load.load) begin
            pc <= pc_load.target;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: source/rv32_decoder.sv
// Combinational RV32I decoder producing operation, register fields and immediate
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module rv32_decoder (
    input  wire logic [`XLEN-1:0]      insn,
    output fetch_isa_pkg::decoded_t    dec
);

    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [`XLEN-1:0]  imm_i;
    logic [`XLEN-1:0]  imm_s;
    logic [`XLEN-1:0]  imm_b;
    logic [`XLEN-1:0]  imm_u;
    logic [`XLEN-1:0]  imm_j;
    logic [`XLEN-1:0]  shamt;

    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    // Immediates of every format take their sign from insn[31]
    assign imm_i = {{(`XLEN-12){insn[31]}}, insn[31:20]};
    assign imm_s = {{(`XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{(`XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    assign shamt = {{(`XLEN-5){1'b0}}, insn[24:20]};   // Shift amount only

    always_comb begin
        dec = '0;
        case (insn[6:0])
            fetch_isa_pkg::maj_lui, fetch_isa_pkg::maj_auipc: begin
                dec.op  = (insn[5]) ? fetch_isa_pkg::op_lui : fetch_isa_pkg::op_auipc;
                dec.rd  = insn[11:7];
                dec.imm = imm_u;
            end
            fetch_isa_pkg::maj_jal: begin
                dec.op  = fetch_isa_pkg::op_jal;
                dec.rd  = insn[11:7];
                dec.imm = imm_j;
            end
            fetch_isa_pkg::maj_jalr: begin
                if (funct3 == 3'b000) dec.op = fetch_isa_pkg::op_jalr;
                dec.rs1 = insn[19:15];
                dec.rd  = insn[11:7];
                dec.imm = imm_i;
            end
            fetch_isa_pkg::maj_branch: begin
                case (funct3)
                    3'b000:  dec.op = fetch_isa_pkg::op_beq;
                    3'b001:  dec.op = fetch_isa_pkg::op_bne;
                    3'b100:  dec.op = fetch_isa_pkg::op_blt;
                    3'b101:  dec.op = fetch_isa_pkg::op_bge;
                    3'b110:  dec.op = fetch_isa_pkg::op_bltu;
                    3'b111:  dec.op = fetch_isa_pkg::op_bgeu;
                    default: dec.op = fetch_isa_pkg::op_none;
                endcase
                dec.rs1 = insn[19:15];
                dec.rs2 = insn[24:20];
                dec.imm = imm_b;
            end
            fetch_isa_pkg::maj_load: begin
                case (funct3)
                    3'b000:  dec.op = fetch_isa_pkg::op_lb;
                    3'b001:  dec.op = fetch_isa_pkg::op_lh;
                    3'b010:  dec.op = fetch_isa_pkg::op_lw;
                    3'b100:  dec.op = fetch_isa_pkg::op_lbu;
                    3'b101:  dec.op = fetch_isa_pkg::op_lhu;
                    default: dec.op = fetch_isa_pkg::op_none;
                endcase
                dec.rs1 = insn[19:15];
                dec.rd  = insn[11:7];
                dec.imm = imm_i;
            end
            fetch_isa_pkg::maj_store: begin
                case (funct3)
                    3'b000:  dec.op = fetch_isa_pkg::op_sb;
                    3'b001:  dec.op = fetch_isa_pkg::op_sh;
                    3'b010:  dec.op = fetch_isa_pkg::op_sw;
                    default: dec.op = fetch_isa_pkg::op_none;
                endcase
                dec.rs1 = insn[19:15];
                dec.rs2 = insn[24:20];
                dec.imm = imm_s;
            end
            fetch_isa_pkg::maj_op_imm: begin
                dec.rs1 = insn[19:15];
                dec.rd  = insn[11:7];
                dec.imm = imm_i;
                case (funct3)
                    3'b000: dec.op = fetch_isa_pkg::op_addi;
                    3'b010: dec.op = fetch_isa_pkg::op_slti;
                    3'b011: dec.op = fetch_isa_pkg::op_sltiu;
                    3'b100: dec.op = fetch_isa_pkg::op_xori;
                    3'b110: dec.op = fetch_isa_pkg::op_ori;
                    3'b111: dec.op = fetch_isa_pkg::op_andi;
                    3'b001: begin
                        if (funct7 == 7'b0000000) dec.op = fetch_isa_pkg::op_slli;
                        dec.imm = shamt;
                    end
                    default: begin   // funct3 101 selects a logical or arithmetic right shift
                        if (funct7 == 7'b0000000) dec.op = fetch_isa_pkg::op_srli;
                        if (funct7 == 7'b0100000) dec.op = fetch_isa_pkg::op_srai;
                        dec.imm = shamt;
                    end
                endcase
            end
            fetch_isa_pkg::maj_op: begin
                dec.rs1 = insn[19:15];
                dec.rs2 = insn[24:20];
                dec.rd  = insn[11:7];
                case ({funct7, funct3})
                    10'b0000000_000: dec.op = fetch_isa_pkg::op_add;
                    10'b0100000_000: dec.op = fetch_isa_pkg::op_sub;
                    10'b0000000_001: dec.op = fetch_isa_pkg::op_sll;
                    10'b0000000_010: dec.op = fetch_isa_pkg::op_slt;
                    10'b0000000_011: dec.op = fetch_isa_pkg::op_sltu;
                    10'b0000000_100: dec.op = fetch_isa_pkg::op_xor;
                    10'b0000000_101: dec.op = fetch_isa_pkg::op_srl;
                    10'b0100000_101: dec.op = fetch_isa_pkg::op_sra;
                    10'b0000000_110: dec.op = fetch_isa_pkg::op_or;
                    10'b0000000_111: dec.op = fetch_isa_pkg::op_and;
                    default:         dec.op = fetch_isa_pkg::op_none;
                endcase
            end
            default: dec.op = fetch_isa_pkg::op_none;
        endcase

        // Control-flow class follows the resolved operation
        case (dec.op)
            fetch_isa_pkg::op_jal:  dec.flow = fetch_isa_pkg::flow_jump;
            fetch_isa_pkg::op_jalr: dec.flow = fetch_isa_pkg::flow_indirect;
            fetch_isa_pkg::op_beq, fetch_isa_pkg::op_bne, fetch_isa_pkg::op_blt,
            fetch_isa_pkg::op_bge, fetch_isa_pkg::op_bltu, fetch_isa_pkg::op_bgeu:
                dec.flow = fetch_isa_pkg::flow_branch;
            fetch_isa_pkg::op_none: dec = '0;   // Unknown word carries no fields
            default:                dec.flow = fetch_isa_pkg::flow_seq;
        endcase
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/fetch_isa_pkg.sv
source/fetch_bus_pkg.sv
source/rv32_decoder.sv
source/pc_unit.sv
source/fetch_control.sv
source/instruction_fetcher.sv
testbench/fetch_assertions.sv
testbench/tb_instruction_fetcher.sv

// File: testbench/fetch_assertions.sv
// Protocol checks bound into the fetch stage top level
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_assertions (
    input wire logic                  clk_in,
    input wire logic                  rst_in,
    input wire logic                  rdy_in,
    input fetch_bus_pkg::cache_req_t  cache_req,
    input fetch_bus_pkg::issue_t      issue,
    input fetch_bus_pkg::redirect_t   flush,
    input wire logic                  jalr_result_en,
    input wire logic [`XLEN-1:0]      jalr_result
);

    int               error_count = 0;   // Read by the testbench monitor
    logic             in_jalr;           // Set from a jalr issue until its target returns
    logic             expect_jalr_req;
    logic [`XLEN-1:0] jalr_target;
    logic             expect_flush;
    logic [`XLEN-1:0] flush_target;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            in_jalr         <= 1'b0;
            expect_jalr_req <= 1'b0;
            expect_flush    <= 1'b0;
            jalr_target     <= '0;
            flush_target    <= '0;
        end else begin
            if (issue.valid && issue.op == fetch_isa_pkg::op_jalr) in_jalr <= 1'b1;
            if (in_jalr && jalr_result_en && rdy_in) begin
                in_jalr         <= 1'b0;
                expect_jalr_req <= 1'b1;
                jalr_target     <= jalr_result;
            end
            if (expect_jalr_req && cache_req.en) expect_jalr_req <= 1'b0;
            if (flush.load && rdy_in) begin
                expect_flush <= 1'b1;
                flush_target <= flush.target;
            end else if (expect_flush && cache_req.en) begin
                expect_flush <= 1'b0;
            end
        end
    end

    // Idle outputs right after reset, then the first request at the reset PC
    a_reset_quiet: assert property (@(posedge clk_in) rst_in |=> !cache_req.en && !issue.valid)
        else begin $error("outputs active after reset"); error_count++; end
    a_first_req: assert property (@(posedge clk_in) disable iff (rst_in)
        $fell(rst_in) |=> cache_req.en && cache_req.pc == `RESET_PC)
        else begin $error("first request not at reset PC"); error_count++; end

    a_jalr_stall: assert property (@(posedge clk_in) disable iff (rst_in)
        in_jalr |-> !cache_req.en)
        else begin $error("request started before jalr result"); error_count++; end
    a_jalr_target: assert property (@(posedge clk_in) disable iff (rst_in)
        expect_jalr_req && cache_req.en |-> cache_req.pc == jalr_target)
        else begin $error("request after jalr not at result"); error_count++; end

    a_flush_quiet: assert property (@(posedge clk_in) disable iff (rst_in)
        expect_flush |-> !issue.valid)
        else begin $error("issue between flush and new request"); error_count++; end
    a_flush_target: assert property (@(posedge clk_in) disable iff (rst_in)
        expect_flush && cache_req.en |-> cache_req.pc == flush_target)
        else begin $error("request after flush not at target"); error_count++; end

    // Issue is a single-cycle pulse
    a_issue_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        issue.valid |=> !issue.valid)
        else begin $error("issue valid on two cycles"); error_count++; end

endmodule

bind instruction_fetcher fetch_assertions u_fetch_assertions (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .cache_req      (cache_req),
    .issue          (issue),
    .flush          (flush),
    .jalr_result_en (jalr_result_en),
    .jalr_result    (jalr_result)
);

`default_nettype wire

// File: testbench/tb_instruction_fetcher.sv
// Testbench for the fetch stage with cache, predictor and ROB models
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module tb_instruction_fetcher;

    localparam int kind_seq    = 0;
    localparam int kind_jump   = 1;
    localparam int kind_branch = 2;
    localparam int kind_jalr   = 3;
    localparam logic [31:0] jalr_target  = 32'h0000_0080;
    localparam logic [31:0] flush_target = 32'h0000_0040;

    logic                      clk_in = 1'b0;
    logic                      rst_in;
    logic                      rdy_in;
    logic                      icache_data_en;
    logic [`XLEN-1:0]          icache_data;
    logic                      predict_result;
    logic                      new_instruction_able;
    fetch_bus_pkg::redirect_t  flush;
    logic                      jalr_result_en;
    logic [`XLEN-1:0]          jalr_result;
    fetch_bus_pkg::cache_req_t cache_req;
    fetch_bus_pkg::issue_t     issue;

    // Program memory and the expected decode of each word
    logic [31:0] prog_word [64];
    logic [6:0]  exp_op [64];
    logic [4:0]  exp_rs1 [64];
    logic [4:0]  exp_rs2 [64];
    logic [4:0]  exp_rd [64];
    logic [31:0] exp_imm [64];
    int          exp_kind [64];

    logic [31:0] lfsr_state = 32'h0ba5b21d;
    logic [31:0] exp_next;
    logic        drv_pred = 1'b0;   // Mirror of predict_result

    instruction_fetcher u_dut (.*);

    always #50 clk_in = ~clk_in;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            report_failure("Value mismatch");
        end
    endtask

    task automatic set_entry(input logic [31:0] addr, input logic [31:0] word,
                             input logic [6:0] op, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [4:0] rd,
                             input logic [31:0] imm, input int kind);
        prog_word[addr[7:2]] = word;
        exp_op[addr[7:2]]    = op;
        exp_rs1[addr[7:2]]   = rs1;
        exp_rs2[addr[7:2]]   = rs2;
        exp_rd[addr[7:2]]    = rd;
        exp_imm[addr[7:2]]   = imm;
        exp_kind[addr[7:2]]  = kind;
    endtask

    // Serve one cache request and check the issued packet
    task automatic fetch_one(input logic hold);
        int          cnt;
        int          lat;
        int          idx;
        logic        applied_pred;
        logic [31:0] req_pc;
        cnt = 0;
        do begin
            @(negedge clk_in);
            cnt++;
            if (cnt > 50) report_failure("Timeout waiting for a cache request");
        end while (!cache_req.en);
        req_pc = cache_req.pc;
        check_value("cache_req.pc", exp_next, req_pc);
        lat = 1 + int'({next_bit(), next_bit()});
        repeat (lat - 1) @(posedge clk_in);
        @(posedge clk_in);
        icache_data_en <= 1'b1;
        icache_data    <= prog_word[req_pc[7:2]];
        @(posedge clk_in);
        icache_data_en <= 1'b0;
        if (hold) begin
            new_instruction_able <= 1'b0;
            repeat (5) begin
                @(posedge clk_in);
                @(negedge clk_in);
                check_value("issue.valid", 32'd0, 32'(issue.valid));
            end
            @(posedge clk_in);
            new_instruction_able <= 1'b1;
            rdy_in               <= 1'b0;   // Frozen even with the dispatcher ready
            repeat (5) begin
                @(posedge clk_in);
                @(negedge clk_in);
                check_value("issue.valid", 32'd0, 32'(issue.valid));
            end
            @(posedge clk_in);
            rdy_in <= 1'b1;
        end
        cnt = 0;
        do begin
            @(posedge clk_in);
            applied_pred = drv_pred;
            drv_pred = next_bit();
            predict_result       <= drv_pred;
            new_instruction_able <= next_bit();
            @(negedge clk_in);
            cnt++;
            if (cnt > 100) report_failure("Timeout waiting for an issue pulse");
        end while (!issue.valid);
        idx = int'(req_pc[7:2]);
        check_value("issue.pc", req_pc, issue.pc);
        check_value("issue.op", 32'(exp_op[idx]), 32'(issue.op));
        check_value("issue.rs1", 32'(exp_rs1[idx]), 32'(issue.rs1));
        check_value("issue.rs2", 32'(exp_rs2[idx]), 32'(issue.rs2));
        check_value("issue.rd", 32'(exp_rd[idx]), 32'(issue.rd));
        check_value("issue.imm", exp_imm[idx], issue.imm);
        check_value("issue.predict_taken", 32'(applied_pred), 32'(issue.predict_taken));
        case (exp_kind[idx])
            kind_jump:   exp_next = req_pc + exp_imm[idx];
            kind_branch: exp_next = applied_pred ? req_pc + exp_imm[idx] : req_pc + 32'd4;
            kind_jalr: begin
                repeat (3) @(posedge clk_in);
                jalr_result_en <= 1'b1;
                jalr_result    <= jalr_target;
                @(posedge clk_in);
                jalr_result_en <= 1'b0;
                exp_next = jalr_target;
            end
            default:     exp_next = req_pc + 32'd4;
        endcase
    endtask

    // Flush an outstanding request that the cache never answers
    task automatic flush_request(input logic [31:0] target);
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk_in);
            cnt++;
            if (cnt > 50) report_failure("Timeout waiting for a request to flush");
        end while (!cache_req.en);
        check_value("cache_req.pc", exp_next, cache_req.pc);
        @(posedge clk_in);
        flush <= {1'b1, target};
        @(posedge clk_in);
        flush <= '0;
        exp_next = target;
    endtask

    always @(negedge clk_in) begin
        if (u_dut.u_fetch_assertions.error_count != 0) report_failure("Protocol assertion failed");
    end

    initial begin
        int steps;
        rst_in = 1'b1;
        rdy_in = 1'b1;
        icache_data_en = 1'b0;
        icache_data = '0;
        predict_result = 1'b0;
        new_instruction_able = 1'b0;
        flush = '0;
        jalr_result_en = 1'b0;
        jalr_result = '0;
        for (int i = 0; i < 64; i++) begin
            set_entry(32'(i * 4), 32'(i * 4), 7'd0, 5'd0, 5'd0, 5'd0, 32'd0, kind_seq);
        end
        set_entry(32'h00, 32'h123450b7, fetch_isa_pkg::op_lui, 0, 0, 1, 32'h12345000, kind_seq);
        set_entry(32'h04, 32'hfffff117, fetch_isa_pkg::op_auipc, 0, 0, 2, 32'hfffff000, kind_seq);
        set_entry(32'h08, 32'hffb08193, fetch_isa_pkg::op_addi, 1, 0, 3, 32'hfffffffb, kind_seq);
        set_entry(32'h0c, 32'h0081a203, fetch_isa_pkg::op_lw, 3, 0, 4, 32'd8, kind_seq);
        set_entry(32'h10, 32'h0041a623, fetch_isa_pkg::op_sw, 3, 4, 0, 32'd12, kind_seq);
        set_entry(32'h14, 32'h403202b3, fetch_isa_pkg::op_sub, 4, 3, 5, 32'd0, kind_seq);
        set_entry(32'h18, 32'h010000ef, fetch_isa_pkg::op_jal, 0, 0, 1, 32'd16, kind_jump);
        set_entry(32'h28, 32'h00208463, fetch_isa_pkg::op_beq, 1, 2, 0, 32'd8, kind_branch);
        set_entry(32'h2c, 32'h00101263, fetch_isa_pkg::op_bne, 0, 1, 0, 32'd4, kind_branch);
        set_entry(32'h30, 32'h00317263, fetch_isa_pkg::op_bgeu, 2, 3, 0, 32'd4, kind_branch);
        set_entry(32'h34, 32'h00008067, fetch_isa_pkg::op_jalr, 1, 0, 0, 32'd0, kind_jalr);
        set_entry(32'h40, 32'h40335393, fetch_isa_pkg::op_srai, 6, 0, 7, 32'd3, kind_seq);
        set_entry(32'h44, 32'h00100313, fetch_isa_pkg::op_addi, 0, 0, 6, 32'd1, kind_seq);
        set_entry(32'h80, 32'h00100313, fetch_isa_pkg::op_addi, 0, 0, 6, 32'd1, kind_seq);
        exp_next = `RESET_PC;
        repeat (8) @(posedge clk_in);
        rst_in <= 1'b0;
        steps = 0;
        while (exp_next != 32'h34) begin
            fetch_one(1'b0);
            steps++;
            if (steps > 20) report_failure("Program never reached the jalr");
        end
        fetch_one(1'b0);               // jalr whose target comes from the ROB model
        flush_request(flush_target);   // Request at the jalr target is dropped
        fetch_one(1'b0);
        fetch_one(1'b1);               // Dispatcher and ready holds
        repeat (3) @(posedge clk_in);
        if (u_dut.u_fetch_assertions.error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_failure("Protocol assertion failed");
        end
    end

endmodule

`default_nettype wire
